// File: source/imuldiv_pkg.sv
// ----------------------------------------
// shared widths, function codes and engine states for the
// iterative mul/div unit, taken by wildcard import in module headers
// ----------------------------------------

package imuldiv_pkg;

  // operand and result widths
  localparam int xlen     = 32;
  localparam int result_w = 64;

  // function codes: bit 1 selects divide, bit 0 selects unsigned
  localparam int fn_w = 2;
  localparam logic [fn_w-1:0] fn_mul  = 2'd0;
  localparam logic [fn_w-1:0] fn_mulu = 2'd1;
  localparam logic [fn_w-1:0] fn_div  = 2'd2;
  localparam logic [fn_w-1:0] fn_divu = 2'd3;

  // one radix-2 step per cycle
  localparam int num_iter = 32;
  localparam int cntr_w   = 5;

  // request transfer edge to resp_val, in cycles
  localparam int latency = 33;

  // ----------------------------------------
  // engine FSM states, shared by both engines
  // ----------------------------------------
  typedef enum logic [1:0] {
    eng_idle,
    eng_calc,
    eng_done
  } eng_state_t;

  // magnitude of an operand, only folded when the op is signed
  function automatic logic [xlen-1:0] op_mag(input logic [xlen-1:0] op,
                                             input logic            is_signed);
    if (is_signed && op[xlen-1])
      return ~op + 1'b1;
    return op;
  endfunction

endpackage

// File: source/imuldiv_int_mul_iterative.sv
// ----------------------------------------
// iterative shift-add multiplier, one product bit per cycle
// val/rdy request in, 64-bit product out after a fixed latency
// ----------------------------------------

`timescale 1ns/1ns

module imuldiv_int_mul_iterative
  import imuldiv_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                req_val,
  output logic                req_rdy,
  input  logic                is_signed,
  input  logic [xlen-1:0]     req_a,
  input  logic [xlen-1:0]     req_b,
  output logic                resp_val,
  input  logic                resp_rdy,
  output logic [result_w-1:0] resp_result
);

  eng_state_t          state;
  logic [cntr_w-1:0]   cntr;
  // set once the sign fix-up has been applied in done
  logic                valid;

  logic [result_w-1:0] acc;
  logic [result_w-1:0] mcand;
  logic [xlen-1:0]     mplier;
  logic                neg;

  logic                req_go;
  logic                resp_go;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // ----------------------------------------
  // control
  // ----------------------------------------

  // only accept work while idle
  assign req_rdy  = (state == eng_idle);
  assign resp_val = valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= eng_idle;
      cntr  <= '0;
      valid <= 1'b0;
    end else begin
      case (state)
        eng_idle: begin
          if (req_go) begin
            state <= eng_calc;
            cntr  <= cntr_w'(num_iter - 1);
          end
        end
        eng_calc: begin
          // counter wraps on the last step, leaving zero as we go to done
          cntr <= cntr - 1'b1;
          if (cntr == '0)
            state <= eng_done;
        end
        eng_done: begin
          // first done cycle fixes the sign, then hold until taken
          if (!valid) begin
            valid <= 1'b1;
          end else if (resp_go) begin
            valid <= 1'b0;
            state <= eng_idle;
          end
        end
        default: state <= eng_idle;
      endcase
    end
  end

  // ----------------------------------------
  // datapath
  // ----------------------------------------

  always_ff @(posedge clk) begin
    case (state)
      eng_idle: begin
        if (req_go) begin
          mcand  <= {{(result_w-xlen){1'b0}}, op_mag(req_a, is_signed)};
          mplier <= op_mag(req_b, is_signed);
          acc    <= '0;
          // product is negative when exactly one signed operand is negative
          neg    <= is_signed && (req_a[xlen-1] ^ req_b[xlen-1]);
        end
      end
      eng_calc: begin
        if (mplier[0])
          acc <= acc + mcand;
        mcand  <= mcand << 1;
        mplier <= mplier >> 1;
      end
      eng_done: begin
        if (!valid && neg)
          acc <= -acc;
      end
      default: ;
    endcase
  end

  assign resp_result = acc;

endmodule

// File: source/imuldiv_int_div_iterative.sv
// ----------------------------------------
// iterative restoring divider, one quotient bit per cycle
// result is {remainder, quotient}, signed ops truncate toward zero
// ----------------------------------------

`timescale 1ns/1ns

module imuldiv_int_div_iterative
  import imuldiv_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                req_val,
  output logic                req_rdy,
  input  logic                is_signed,
  input  logic [xlen-1:0]     req_a,
  input  logic [xlen-1:0]     req_b,
  output logic                resp_val,
  input  logic                resp_rdy,
  output logic [result_w-1:0] resp_result
);

  eng_state_t          state;
  logic [cntr_w-1:0]   cntr;
  logic                valid;

  // remainder in the upper half, quotient shifts in from the bottom
  logic [result_w:0]   rq;
  // divisor parked in the upper half so it lines up with the remainder
  logic [result_w:0]   dvsr;
  logic                quot_neg;
  logic                rem_neg;

  logic [result_w:0]   rq_shift;
  logic [result_w:0]   rq_diff;
  logic [xlen-1:0]     quot;
  logic [xlen-1:0]     rem;

  logic                req_go;
  logic                resp_go;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // ----------------------------------------
  // control
  // ----------------------------------------

  assign req_rdy  = (state == eng_idle);
  assign resp_val = valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= eng_idle;
      cntr  <= '0;
      valid <= 1'b0;
    end else begin
      case (state)
        eng_idle: begin
          if (req_go) begin
            state <= eng_calc;
            cntr  <= cntr_w'(num_iter - 1);
          end
        end
        eng_calc: begin
          cntr <= cntr - 1'b1;
          if (cntr == '0)
            state <= eng_done;
        end
        eng_done: begin
          // sign fix-up takes the first done cycle
          if (!valid) begin
            valid <= 1'b1;
          end else if (resp_go) begin
            valid <= 1'b0;
            state <= eng_idle;
          end
        end
        default: state <= eng_idle;
      endcase
    end
  end

  // ----------------------------------------
  // datapath
  // ----------------------------------------

  // shift then trial subtract, msb of the difference says it went negative
  assign rq_shift = rq << 1;
  assign rq_diff  = rq_shift - dvsr;

  assign quot = rq[xlen-1:0];
  assign rem  = rq[result_w-1:xlen];

  always_ff @(posedge clk) begin
    case (state)
      eng_idle: begin
        if (req_go) begin
          rq       <= {{(result_w-xlen+1){1'b0}}, op_mag(req_a, is_signed)};
          dvsr     <= {1'b0, op_mag(req_b, is_signed), {xlen{1'b0}}};
          quot_neg <= is_signed && (req_a[xlen-1] ^ req_b[xlen-1]);
          // remainder follows the dividend
          rem_neg  <= is_signed && req_a[xlen-1];
        end
      end
      eng_calc: begin
        if (rq_diff[result_w])
          // restore, quotient bit 0 is already in the shifted value
          rq <= rq_shift;
        else
          rq <= {rq_diff[result_w:1], 1'b1};
      end
      eng_done: begin
        if (!valid) begin
          rq[xlen-1:0]        <= quot_neg ? -quot : quot;
          rq[result_w-1:xlen] <= rem_neg ? -rem : rem;
        end
      end
      default: ;
    endcase
  end

  assign resp_result = rq[result_w-1:0];

endmodule

// File: source/imuldiv_muldiv_router.sv
// ----------------------------------------
// sends each request to the mul or div engine and steers the
// owning engine's response back out, one op in flight
// ----------------------------------------

`timescale 1ns/1ns

module imuldiv_muldiv_router
  import imuldiv_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic [fn_w-1:0]     req_fn,
  input  logic                req_val,
  output logic                req_rdy,
  output logic                is_signed,
  output logic                mul_req_val,
  output logic                div_req_val,
  input  logic                mul_req_rdy,
  input  logic                div_req_rdy,
  input  logic                mul_resp_val,
  input  logic                div_resp_val,
  input  logic [result_w-1:0] mul_resp_result,
  input  logic [result_w-1:0] div_resp_result,
  output logic                mul_resp_rdy,
  output logic                div_resp_rdy,
  output logic                resp_val,
  output logic [result_w-1:0] resp_result,
  input  logic                resp_rdy
);

  typedef enum logic [1:0] {
    own_none,
    own_mul,
    own_div
  } owner_t;

  owner_t owner;
  logic   sel_div;
  logic   free;

  // ----------------------------------------
  // request side
  // ----------------------------------------

  assign sel_div   = req_fn[1];
  assign is_signed = (req_fn == fn_mul) || (req_fn == fn_div);
  assign free      = (owner == own_none);

  // strobes only need a free slot, never the engine's rdy
  assign mul_req_val = req_val && free && !sel_div;
  assign div_req_val = req_val && free && sel_div;
  assign req_rdy     = free && (sel_div ? div_req_rdy : mul_req_rdy);

  always_ff @(posedge clk) begin
    if (reset)
      owner <= own_none;
    else if (req_val && req_rdy)
      owner <= sel_div ? own_div : own_mul;
    else if (resp_val && resp_rdy)
      owner <= own_none;
  end

  // ----------------------------------------
  // response side follows the owner
  // ----------------------------------------

  assign resp_val     = (owner == own_mul) ? mul_resp_val :
                        (owner == own_div) ? div_resp_val : 1'b0;
  assign resp_result  = (owner == own_div) ? div_resp_result : mul_resp_result;
  assign mul_resp_rdy = (owner == own_mul) && resp_rdy;
  assign div_resp_rdy = (owner == own_div) && resp_rdy;

endmodule

// File: source/imuldiv_int_muldiv_iterative.sv
// ----------------------------------------
// iterative integer mul/div unit, top level
// router plus one shift-add multiplier and one restoring divider
// ----------------------------------------

`timescale 1ns/1ns

module imuldiv_int_muldiv_iterative
  import imuldiv_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic [fn_w-1:0]     req_fn,
  input  logic [xlen-1:0]     req_a,
  input  logic [xlen-1:0]     req_b,
  input  logic                req_val,
  output logic                req_rdy,
  output logic [result_w-1:0] resp_result,
  output logic                resp_val,
  input  logic                resp_rdy
);

  logic                is_signed;

  // multiplier side
  logic                mul_req_val;
  logic                mul_req_rdy;
  logic                mul_resp_val;
  logic                mul_resp_rdy;
  logic [result_w-1:0] mul_resp_result;

  // divider side
  logic                div_req_val;
  logic                div_req_rdy;
  logic                div_resp_val;
  logic                div_resp_rdy;
  logic [result_w-1:0] div_resp_result;

  imuldiv_muldiv_router router (
    .clk             (clk),
    .reset           (reset),
    .req_fn          (req_fn),
    .req_val         (req_val),
    .req_rdy         (req_rdy),
    .is_signed       (is_signed),
    .mul_req_val     (mul_req_val),
    .div_req_val     (div_req_val),
    .mul_req_rdy     (mul_req_rdy),
    .div_req_rdy     (div_req_rdy),
    .mul_resp_val    (mul_resp_val),
    .div_resp_val    (div_resp_val),
    .mul_resp_result (mul_resp_result),
    .div_resp_result (div_resp_result),
    .mul_resp_rdy    (mul_resp_rdy),
    .div_resp_rdy    (div_resp_rdy),
    .resp_val        (resp_val),
    .resp_result     (resp_result),
    .resp_rdy        (resp_rdy)
  );

  // operands go straight to both engines, only the strobes differ
  imuldiv_int_mul_iterative mul (
    .clk         (clk),
    .reset       (reset),
    .req_val     (mul_req_val),
    .req_rdy     (mul_req_rdy),
    .is_signed   (is_signed),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (mul_resp_val),
    .resp_rdy    (mul_resp_rdy),
    .resp_result (mul_resp_result)
  );

  imuldiv_int_div_iterative div (
    .clk         (clk),
    .reset       (reset),
    .req_val     (div_req_val),
    .req_rdy     (div_req_rdy),
    .is_signed   (is_signed),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (div_resp_val),
    .resp_rdy    (div_resp_rdy),
    .resp_result (div_resp_result)
  );

endmodule

// File: tb/imuldiv_tb_clock.sv
// ----------------------------------------
// testbench clock and reset for the mul/div unit
// 100 ns clock, reset held high over the first 8 rising edges
// ----------------------------------------

`timescale 1ns/1ns

module imuldiv_tb_clock (
  output logic clk,
  output logic reset
);

  localparam int half_period  = 50;
  localparam int reset_cycles = 8;
  // reset drops this long after the last reset edge
  localparam int release_dly  = 10;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #release_dly;
    reset = 1'b0;
  end

endmodule

// File: tb/imuldiv_tb.sv
// ----------------------------------------
// testbench for the iterative mul/div unit, random ops per function
// expected results come from 64-bit arithmetic, assertions check them
// ----------------------------------------

`timescale 1ns/1ns

module imuldiv_tb
  import imuldiv_pkg::*;
();

  localparam int ops_per_fn = 50;
  localparam int drive_dly  = 10;
  // 200 ops at up to 45 cycles each is 9000, doubled plus margin
  localparam int max_cycles = 20000;

  logic                clk;
  logic                reset;
  logic [fn_w-1:0]     req_fn;
  logic [xlen-1:0]     req_a;
  logic [xlen-1:0]     req_b;
  logic                req_val;
  logic                req_rdy;
  logic [result_w-1:0] resp_result;
  logic                resp_val;
  logic                resp_rdy;

  // expected result and latency count of the op in flight
  logic [result_w-1:0] exp_result;
  logic                busy;
  int                  lat_cnt;
  int                  cycles = 0;

  // previous-edge copies for the stability checks
  logic                prev_reset = 1'b0;
  logic                prev_val = 1'b0;
  logic                prev_hold = 1'b0;
  logic [result_w-1:0] prev_result;

  int                  result_errs = 0;
  int                  latency_errs = 0;
  int                  handshake_errs = 0;

  imuldiv_tb_clock clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  imuldiv_int_muldiv_iterative dut (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  // ----------------------------------------
  // reference model
  // ----------------------------------------

  // SV / and % on signed values truncate toward zero,
  // remainder keeps the dividend's sign
  function automatic logic [result_w-1:0] expected_result(input logic [fn_w-1:0] fn,
                                                          input logic [xlen-1:0] a,
                                                          input logic [xlen-1:0] b);
    longint          sa;
    longint          sb;
    longint unsigned ua;
    longint unsigned ub;
    logic [xlen-1:0] q;
    logic [xlen-1:0] r;
    sa = $signed(a);
    sb = $signed(b);
    ua = 64'(a);
    ub = 64'(b);
    case (fn)
      fn_mul:  return 64'(sa * sb);
      fn_mulu: return 64'(ua * ub);
      fn_div: begin
        q = xlen'(sa / sb);
        r = xlen'(sa % sb);
      end
      default: begin
        q = xlen'(ua / ub);
        r = xlen'(ua % ub);
      end
    endcase
    return {r, q};
  endfunction

  // ----------------------------------------
  // request and response tracking
  // ----------------------------------------

  always @(posedge clk) begin
    prev_reset  <= reset;
    prev_val    <= resp_val;
    prev_hold   <= resp_val && !resp_rdy;
    prev_result <= resp_result;
    if (reset) begin
      busy    <= 1'b0;
      lat_cnt <= 0;
    end else begin
      if (req_val && req_rdy) begin
        busy       <= 1'b1;
        lat_cnt    <= 0;
        exp_result <= expected_result(req_fn, req_a, req_b);
      end else if (busy) begin
        lat_cnt <= lat_cnt + 1;
      end
      if (resp_val && resp_rdy)
        busy <= 1'b0;
    end
  end

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ----------------------------------------
  // assertions
  // ----------------------------------------

  // reset values, also on the first edge out of reset
  reset_rdy_check: assert property (@(posedge clk) prev_reset |-> req_rdy)
    else begin
      handshake_errs++;
      $display("[ERROR] %0t req_rdy expected 1 got %b", $time, $sampled(req_rdy));
    end

  reset_val_check: assert property (@(posedge clk) prev_reset |-> !resp_val)
    else begin
      handshake_errs++;
      $display("[ERROR] %0t resp_val expected 0 got %b", $time, $sampled(resp_val));
    end

  result_check: assert property (@(posedge clk) disable iff (reset)
    resp_val && resp_rdy |-> resp_result == exp_result)
    else begin
      result_errs++;
      $display("[ERROR] %0t resp_result expected %h got %h", $time,
               $sampled(exp_result), $sampled(resp_result));
    end

  // resp_val rises a fixed number of cycles after the request edge
  latency_check: assert property (@(posedge clk) disable iff (reset)
    resp_val && !prev_val |-> lat_cnt == latency)
    else begin
      latency_errs++;
      $display("[ERROR] %0t resp_val latency expected %0d got %0d", $time,
               latency, $sampled(lat_cnt));
    end

  busy_rdy_check: assert property (@(posedge clk) disable iff (reset) busy |-> !req_rdy)
    else begin
      handshake_errs++;
      $display("[ERROR] %0t req_rdy expected 0 got 1 with an op in flight", $time);
    end

  idle_val_check: assert property (@(posedge clk) disable iff (reset) !busy |-> !resp_val)
    else begin
      handshake_errs++;
      $display("[ERROR] %0t resp_val expected 0 got 1 with no op in flight", $time);
    end

  // back-pressure keeps the response in place
  hold_val_check: assert property (@(posedge clk) disable iff (reset) prev_hold |-> resp_val)
    else begin
      handshake_errs++;
      $display("[ERROR] %0t resp_val expected 1 got 0 under back-pressure", $time);
    end

  hold_result_check: assert property (@(posedge clk) disable iff (reset)
    prev_hold |-> resp_result == prev_result)
    else begin
      handshake_errs++;
      $display("[ERROR] %0t resp_result expected %h got %h under back-pressure", $time,
               $sampled(prev_result), $sampled(resp_result));
    end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------

  // corner values show up often next to plain random ones
  function automatic logic [xlen-1:0] pick_operand();
    int kind;
    kind = $urandom_range(7, 0);
    case (kind)
      0: return '0;
      1: return 32'h8000_0000;
      2: return 32'hffff_ffff;
      3: return 32'h7fff_ffff;
      4: return $urandom_range(255, 0);
      default: return $urandom();
    endcase
  endfunction

  // entered and left 10 ns after a rising edge
  task automatic do_op(input logic [fn_w-1:0] fn, input logic [xlen-1:0] a,
                       input logic [xlen-1:0] b);
    logic seen;
    int   hold;
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    req_val = 1'b1;
    // rdy sampled mid-cycle, the next edge then takes the request
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk);
      seen = req_rdy;
      @(posedge clk);
    end
    #drive_dly;
    req_val = 1'b0;
    // resp_val is looked at just after each edge, once it has settled
    while (!resp_val) begin
      @(posedge clk);
      #drive_dly;
    end
    // stall the response for a while before taking it
    hold = $urandom_range(5, 0);
    repeat (hold) begin
      @(posedge clk);
      #drive_dly;
    end
    resp_rdy = 1'b1;
    @(posedge clk);
    #drive_dly;
    resp_rdy = 1'b0;
  endtask

  task automatic run_fn(input logic [fn_w-1:0] fn);
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    int              i;
    for (i = 0; i < ops_per_fn; i++) begin
      a = pick_operand();
      b = pick_operand();
      if (fn == fn_div) begin
        // walk all four sign combinations
        a = {1'b0, a[xlen-2:0]};
        b = {1'b0, b[xlen-2:0]};
        if (i[0])
          a = -a;
        if (i[1])
          b = -b;
        if (i % 10 == 7)
          a = 32'h8000_0000;
        if (i % 10 == 8)
          b = 32'd1;
        if (i % 10 == 9)
          b = 32'hffff_ffff;
      end
      // zero divisor is outside the design
      if (fn[1] && b == '0)
        b = 32'd3;
      do_op(fn, a, b);
    end
  endtask

  initial begin
    req_val  = 1'b0;
    req_fn   = fn_mul;
    req_a    = '0;
    req_b    = '0;
    resp_rdy = 1'b0;
    void'($urandom(32'h19de_bae4));
    @(negedge reset);
    @(posedge clk);
    #drive_dly;
    run_fn(fn_mulu);
    run_fn(fn_mul);
    run_fn(fn_divu);
    run_fn(fn_div);
    repeat (2) @(posedge clk);
    $display("errors: result %0d, latency %0d, handshake %0d",
             result_errs, latency_errs, handshake_errs);
    if (result_errs + latency_errs + handshake_errs == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: filelist.f
source/imuldiv_pkg.sv
source/imuldiv_int_mul_iterative.sv
source/imuldiv_int_div_iterative.sv
source/imuldiv_muldiv_router.sv
source/imuldiv_int_muldiv_iterative.sv
tb/imuldiv_tb_clock.sv
tb/imuldiv_tb.sv

// File: Makefile
# Verilator build for the iterative mul/div unit and its testbench

VERILATOR ?= verilator
TOP       ?= imuldiv_tb
RTL_TOP   ?= imuldiv_int_muldiv_iterative
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= STATUS: PASS

.PHONY: all lint build sim clean

all: sim

# lint the RTL on its own, then the whole bench
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) \
		$(filter source/%,$(shell cat $(FILELIST)))
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass line shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
